/* tests/matrix_stimulus.txt */
# S byte | C rgb brightness | M addr data | N writes since last N
# values in hex, only the N count is decimal
C 7 3F
N 0
S 72
S 67
S 42
C 4 3F
S 30
S 32
C 4 10
S 36
C 4 11
S 54
S 15
C 4 15
S 39
C 4 3F
S 50
S 03
S 05
S A1
S B2
N 2
M 18B A1
M 18A B2
M 18C 5E
S 46
S 12
S 34
N 4096
M 000 34
M 001 12
M 18A 34
M 18B 12
M 7FF 12
M FFE 34
M FFF 12
S 5A
S 52
S 31
N 4096
M 000 00
M 18B 00
M FFF 00
C 5 1F
S 78
S FF
C 5 1F
N 0

/* list.f */
verilog/matrix_pkg.sv
verilog/cmd_byte_rx.sv
verilog/cmd_decoder.sv
verilog/pixel_writer.sv
verilog/display_settings.sv
verilog/matrix_ctrl_top.sv
tests/tb_matrix_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# builds the matrix controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_matrix_ctrl \
    -f list.f -o sim_tb_matrix_ctrl

sim_output=$(./obj_dir/sim_tb_matrix_ctrl 2>&1) || true
echo "$sim_output"

# exit status follows the search for the pass line
echo "$sim_output" | grep -q "^TESTS PASSED$"

/* tests/tb_matrix_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
//****************************************
// run from the project root to find tests/matrix_stimulus.txt
// stops at the first wrong value
//****************************************
module tb_matrix_ctrl
    import matrix_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 10000;
    localparam int RAM_DEPTH      = 1 << RAM_ADDR_BITS;

    logic        clk_in;
    logic        reset;
    logic        rx_req;
    cmd_byte_t   rx_data;
    logic        rx_ack;
    ram_addr_t   ram_addr;
    ram_data_t   ram_data;
    logic        ram_we;
    rgb_mask_t   rgb_enable;
    brightness_t brightness_enable;
    logic        busy;

    ram_data_t shadow_ram [RAM_DEPTH];
    int        write_count;
    int        count_mark;
    int        checks_run;
    int        stim_fd;

    matrix_ctrl_top UUT (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_req            (rx_req),
        .rx_data           (rx_data),
        .rx_ack            (rx_ack),
        .ram_addr          (ram_addr),
        .ram_data          (ram_data),
        .ram_we            (ram_we),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .busy              (busy)
    );

    initial begin : clock_gen
        clk_in = 1'b0;
        forever begin
            #5 clk_in = ~clk_in;
        end
    end

    // untouched locations keep a pattern of their whole address
    function automatic ram_data_t fill_pattern(input ram_addr_t a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'hc3;
    endfunction

    // shadow of the frame RAM sampled mid cycle
    initial begin : ram_model
        write_count = 0;
        for (int a = 0; a < RAM_DEPTH; a++) begin
            shadow_ram[a] = fill_pattern(ram_addr_t'(a));
        end
        forever begin
            @(negedge clk_in);
            if (ram_we === 1'b1) begin
                shadow_ram[ram_addr] = ram_data;
                write_count = write_count + 1;
            end
        end
    end

    task automatic fail_and_stop(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic value, input logic expected);
        checks_run++;
        if (value !== expected) begin
            fail_and_stop($sformatf("MISMATCH %s got %h expected %h", name, value, expected));
        end
    endtask

    task automatic check_rgb(input rgb_mask_t expected);
        checks_run++;
        if (rgb_enable !== expected) begin
            fail_and_stop($sformatf("MISMATCH rgb_enable got %h expected %h",
                                    rgb_enable, expected));
        end
    endtask

    task automatic check_brightness(input brightness_t expected);
        checks_run++;
        if (brightness_enable !== expected) begin
            fail_and_stop($sformatf("MISMATCH brightness_enable got %h expected %h",
                                    brightness_enable, expected));
        end
    endtask

    task automatic check_ram(input ram_addr_t addr, input ram_data_t expected);
        checks_run++;
        if (shadow_ram[addr] !== expected) begin
            fail_and_stop($sformatf("MISMATCH ram_data at %h got %h expected %h",
                                    addr, shadow_ram[addr], expected));
        end
    endtask

    task automatic check_count(input int expected);
        checks_run++;
        if (write_count - count_mark != expected) begin
            fail_and_stop($sformatf("MISMATCH ram_we count got %h expected %h",
                                    write_count - count_mark, expected));
        end
        count_mark = write_count;
    endtask

    task automatic wait_for_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (rx_ack !== level) begin
            @(posedge clk_in);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_and_stop(what);
            end
        end
    endtask

    // four phase handshake with inputs moved 1 ns after the edge
    task automatic send_byte(input cmd_byte_t value);
        @(posedge clk_in);
        #1;
        rx_data = value;
        rx_req  = 1'b1;
        wait_for_ack(1'b1, "timeout waiting for rx_ack to rise");
        rx_req = 1'b0;
        wait_for_ack(1'b0, "timeout waiting for rx_ack to fall");
    endtask

    task automatic wait_until_idle();
        int cycles;
        cycles = 0;
        @(negedge clk_in);
        while (busy !== 1'b0) begin
            @(negedge clk_in);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_and_stop("timeout waiting for busy to fall");
            end
        end
        @(posedge clk_in);
        #1;
    endtask

    initial begin : run_tests
        int op;
        int got;
        int arg_a;
        int arg_b;
        checks_run = 0;
        count_mark = 0;
        rx_req     = 1'b0;
        rx_data    = '0;
        reset      = 1'b1;
        repeat (5) @(posedge clk_in);
        #1;
        reset = 1'b0;
        check_flag("rx_ack", rx_ack, 1'b0);
        check_flag("ram_we", ram_we, 1'b0);
        check_flag("busy", busy, 1'b0);

        stim_fd = $fopen("tests/matrix_stimulus.txt", "r");
        if (stim_fd == 0) begin
            fail_and_stop("could not open tests/matrix_stimulus.txt");
        end
        op = $fgetc(stim_fd);
        while (op != -1) begin
            case (op)
                "#": begin
                    while (op != 10 && op != -1) begin
                        op = $fgetc(stim_fd);
                    end
                end
                "S": begin
                    got = $fscanf(stim_fd, "%h", arg_a);
                    if (got != 1) fail_and_stop("bad S record in stimulus file");
                    send_byte(cmd_byte_t'(arg_a));
                end
                "C": begin
                    got = $fscanf(stim_fd, "%h %h", arg_a, arg_b);
                    if (got != 2) fail_and_stop("bad C record in stimulus file");
                    wait_until_idle();
                    check_rgb(rgb_mask_t'(arg_a));
                    check_brightness(brightness_t'(arg_b));
                end
                "M": begin
                    got = $fscanf(stim_fd, "%h %h", arg_a, arg_b);
                    if (got != 2) fail_and_stop("bad M record in stimulus file");
                    wait_until_idle();
                    check_ram(ram_addr_t'(arg_a), ram_data_t'(arg_b));
                end
                "N": begin
                    got = $fscanf(stim_fd, "%d", arg_a);
                    if (got != 1) fail_and_stop("bad N record in stimulus file");
                    wait_until_idle();
                    check_count(arg_a);
                end
                " ", 9, 10, 13: begin
                end
                default: fail_and_stop("unknown record type in stimulus file");
            endcase
            op = $fgetc(stim_fd);
        end
        $fclose(stim_fd);

        if (checks_run > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
`default_nettype wire

/* verilog/matrix_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none
//****************************************
// host holds rx_req through busy, ram_we has no handshake
//****************************************
module matrix_ctrl_top
    import matrix_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic        rx_req,
    input  cmd_byte_t   rx_data,
    output logic        rx_ack,
    output ram_addr_t   ram_addr,
    output ram_data_t   ram_data,
    output logic        ram_we,
    output rgb_mask_t   rgb_enable,
    output brightness_t brightness_enable,
    output logic        busy
);

    logic         byte_valid;
    cmd_byte_t    byte_data;
    logic         ready;
    settings_op_t settings_op;
    cmd_byte_t    settings_arg;
    logic         write_start;
    write_mode_t  write_mode;
    row_addr_t    row;
    col_addr_t    col;
    pixel_word_t  pixel_word;
    logic         writer_busy;

    cmd_byte_rx rx (
        .clk_in     (clk_in),
        .reset      (reset),
        .rx_req     (rx_req),
        .rx_data    (rx_data),
        .ready      (ready),
        .rx_ack     (rx_ack),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    cmd_decoder decoder (
        .clk_in       (clk_in),
        .reset        (reset),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .writer_busy  (writer_busy),
        .ready        (ready),
        .busy         (busy),
        .settings_op  (settings_op),
        .settings_arg (settings_arg),
        .write_start  (write_start),
        .write_mode   (write_mode),
        .row          (row),
        .col          (col),
        .pixel_word   (pixel_word)
    );

    pixel_writer writer (
        .clk_in      (clk_in),
        .reset       (reset),
        .write_start (write_start),
        .write_mode  (write_mode),
        .row         (row),
        .col         (col),
        .pixel_word  (pixel_word),
        .writer_busy (writer_busy),
        .ram_addr    (ram_addr),
        .ram_data    (ram_data),
        .ram_we      (ram_we)
    );

    display_settings settings (
        .clk_in            (clk_in),
        .reset             (reset),
        .settings_op       (settings_op),
        .settings_arg      (settings_arg),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

endmodule
`default_nettype wire

/* verilog/display_settings.sv */
`timescale 1ns/1ps
`default_nettype none
//****************************************
// all channels and planes enabled out of reset
//****************************************
module display_settings
    import matrix_pkg::*;
(
    input  logic         clk_in,
    input  logic         reset,
    input  settings_op_t settings_op,
    input  cmd_byte_t    settings_arg,
    output rgb_mask_t    rgb_enable,
    output brightness_t  brightness_enable
);

    // upper and lower case letters hit the same channel
    function automatic rgb_mask_t colour_mask(input cmd_byte_t arg);
        case (arg)
            CMD_RED_ON, CMD_RED_OFF:     return 3'b001;
            CMD_GREEN_ON, CMD_GREEN_OFF: return 3'b010;
            CMD_BLUE_ON, CMD_BLUE_OFF:   return 3'b100;
            default:                     return 3'b000;
        endcase
    endfunction

    // digit n selects plane BRIGHTNESS_LEVELS - n
    function automatic brightness_t plane_mask(input cmd_byte_t arg);
        brightness_t mask;
        int          level;
        level = int'(arg[3:0]);
        mask  = '0;
        for (int i = 0; i < BRIGHTNESS_LEVELS; i++) begin
            if (i == BRIGHTNESS_LEVELS - level) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            case (settings_op)
                set_rgb:      rgb_enable <= rgb_enable | colour_mask(settings_arg);
                clr_rgb:      rgb_enable <= rgb_enable & ~colour_mask(settings_arg);
                toggle_plane: brightness_enable <= brightness_enable ^ plane_mask(settings_arg);
                all_off:      brightness_enable <= '0;
                all_on:       brightness_enable <= '1;
                load_planes:  brightness_enable <= settings_arg[BRIGHTNESS_LEVELS-1:0];
                default: begin
                end
            endcase
        end
    end

endmodule
`default_nettype wire

/* verilog/pixel_writer.sv */
`timescale 1ns/1ps
`default_nettype none
//****************************************
// plain write strobe, the RAM must take a byte every cycle
// inputs are sampled only on write_start
//****************************************
module pixel_writer
    import matrix_pkg::*;
(
    input  logic        clk_in,
    input  logic        reset,
    input  logic        write_start,
    input  write_mode_t write_mode,
    input  row_addr_t   row,
    input  col_addr_t   col,
    input  pixel_word_t pixel_word,
    output logic        writer_busy,
    output ram_addr_t   ram_addr,
    output ram_data_t   ram_data,
    output logic        ram_we
);

    logic        active;
    write_mode_t mode_q;
    pixel_word_t word_q;
    ram_addr_t   next_addr;
    logic        last_write;

    assign writer_busy = active;
    assign next_addr   = ram_addr + 1'b1;

    // pixel ends after slot 0, fill and blank after the top address
    always_comb begin
        if (mode_q == pixel) begin
            last_write = !ram_addr[0];
        end else begin
            last_write = (ram_addr == {RAM_ADDR_BITS{1'b1}});
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active   <= 1'b0;
            ram_we   <= 1'b0;
            ram_addr <= '0;
            mode_q   <= pixel;
        end else begin
            ram_we <= 1'b0;
            if (write_start) begin
                active <= 1'b1;
                ram_we <= 1'b1;
                mode_q <= write_mode;
                // big endian, high byte lands in slot 1
                if (write_mode == pixel) begin
                    ram_addr <= {row, col, 1'b1};
                end else begin
                    ram_addr <= '0;
                end
            end else if (active) begin
                if (last_write) begin
                    active <= 1'b0;
                end else begin
                    ram_we <= 1'b1;
                    if (mode_q == pixel) begin
                        ram_addr <= {ram_addr[RAM_ADDR_BITS-1:1], 1'b0};
                    end else begin
                        ram_addr <= next_addr;
                    end
                end
            end
        end
    end

    // data path, follows the address chosen above
    always_ff @(posedge clk_in) begin
        if (write_start) begin
            word_q <= pixel_word;
            case (write_mode)
                pixel:   ram_data <= pixel_word[15:8];
                fill:    ram_data <= pixel_word[7:0];
                default: ram_data <= 8'h00;
            endcase
        end else if (active && !last_write) begin
            case (mode_q)
                pixel:   ram_data <= word_q[7:0];
                fill:    ram_data <= next_addr[0] ? word_q[15:8] : word_q[7:0];
                default: ram_data <= 8'h00;
            endcase
        end
    end

endmodule
`default_nettype wire

/* verilog/cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
//****************************************
// settings ops are combinational on byte_valid
// write_start is registered, one cycle after the last argument
//****************************************
module cmd_decoder
    import matrix_pkg::*;
(
    input  logic         clk_in,
    input  logic         reset,
    input  logic         byte_valid,
    input  cmd_byte_t    byte_data,
    input  logic         writer_busy,
    output logic         ready,
    output logic         busy,
    output settings_op_t settings_op,
    output cmd_byte_t    settings_arg,
    output logic         write_start,
    output write_mode_t  write_mode,
    output row_addr_t    row,
    output col_addr_t    col,
    output pixel_word_t  pixel_word
);

    decoder_state_t state;

    assign ready        = (state != wait_writer);
    assign busy         = (state != idle);
    assign settings_arg = byte_data;

    // single byte commands map straight onto a settings op
    always_comb begin
        settings_op = none;
        if (byte_valid && state == get_brightness) begin
            settings_op = load_planes;
        end else if (byte_valid && state == idle) begin
            case (byte_data) inside
                CMD_RED_ON, CMD_GREEN_ON, CMD_BLUE_ON:    settings_op = set_rgb;
                CMD_RED_OFF, CMD_GREEN_OFF, CMD_BLUE_OFF: settings_op = clr_rgb;
                [CMD_PLANE_FIRST:CMD_PLANE_LAST]:         settings_op = toggle_plane;
                CMD_PLANES_OFF:                           settings_op = all_off;
                CMD_PLANES_ON:                            settings_op = all_on;
                default:                                  settings_op = none;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state       <= idle;
            write_start <= 1'b0;
            write_mode  <= pixel;
        end else begin
            write_start <= 1'b0;
            case (state)
                idle: begin
                    if (byte_valid) begin
                        case (byte_data)
                            CMD_LOAD_PLANES: state <= get_brightness;
                            CMD_PIXEL: begin
                                write_mode <= pixel;
                                state      <= get_row;
                            end
                            CMD_FILL: begin
                                write_mode <= fill;
                                state      <= get_hi;
                            end
                            // no arguments, start straight away
                            CMD_BLANK: begin
                                write_mode  <= blank;
                                write_start <= 1'b1;
                                state       <= wait_writer;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                get_brightness: if (byte_valid) state <= idle;
                get_row:        if (byte_valid) state <= get_col;
                get_col:        if (byte_valid) state <= get_hi;
                get_hi:         if (byte_valid) state <= get_lo;
                get_lo: begin
                    if (byte_valid) begin
                        write_start <= 1'b1;
                        state       <= wait_writer;
                    end
                end
                // writer_busy only rises the cycle after write_start
                wait_writer: begin
                    if (!write_start && !writer_busy) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // argument capture
    always_ff @(posedge clk_in) begin
        if (byte_valid) begin
            case (state)
                get_row: row                         <= byte_data[ROW_BITS-1:0];
                get_col: col                         <= byte_data[COL_BITS-1:0];
                get_hi:  pixel_word[15:8]            <= byte_data;
                get_lo:  pixel_word[7:0]             <= byte_data;
                default: begin
                end
            endcase
        end
    end

endmodule
`default_nettype wire

/* verilog/cmd_byte_rx.sv */
`timescale 1ns/1ps
`default_nettype none
//****************************************
// rx_req may be asynchronous, rx_data must hold while req is high
// ack rises three cycles after req at the earliest
//****************************************
module cmd_byte_rx
    import matrix_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset,
    input  logic      rx_req,
    input  cmd_byte_t rx_data,
    input  logic      ready,
    output logic      rx_ack,
    output logic      byte_valid,
    output cmd_byte_t byte_data
);

    logic req_meta;
    logic req_sync;
    logic take;

    // two flop synchroniser on the host request
    always_ff @(posedge clk_in) begin
        if (reset) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
        end else begin
            req_meta <= rx_req;
            req_sync <= req_meta;
        end
    end

    // new request, not yet acked, and decoder can take it
    assign take = req_sync && !rx_ack && ready;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_ack     <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= take;
            if (take) begin
                rx_ack <= 1'b1;
            end else if (!req_sync) begin
                rx_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            byte_data <= rx_data;
        end
    end

endmodule
`default_nettype wire

/* verilog/matrix_pkg.sv */
`default_nettype none
//****************************************
// fixed 64 x 32 panel at two bytes per pixel
// command codes are plain ascii bytes
//****************************************
package matrix_pkg;

    // panel geometry
    localparam int PANEL_ROWS        = 32;
    localparam int PANEL_COLS        = 64;
    localparam int BYTES_PER_PIXEL   = 2;
    localparam int BRIGHTNESS_LEVELS = 6;

    localparam int ROW_BITS      = $clog2(PANEL_ROWS);
    localparam int COL_BITS      = $clog2(PANEL_COLS);
    localparam int RAM_ADDR_BITS = $clog2(PANEL_ROWS * PANEL_COLS * BYTES_PER_PIXEL);

    typedef logic [7:0]                     cmd_byte_t;
    typedef logic [ROW_BITS-1:0]            row_addr_t;
    typedef logic [COL_BITS-1:0]            col_addr_t;
    // row, then column, then byte slot
    typedef logic [RAM_ADDR_BITS-1:0]       ram_addr_t;
    typedef logic [7:0]                     ram_data_t;
    typedef logic [8*BYTES_PER_PIXEL-1:0]   pixel_word_t;
    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0]                     rgb_mask_t;
    typedef logic [BRIGHTNESS_LEVELS-1:0]   brightness_t;

    // host command bytes
    localparam cmd_byte_t CMD_RED_ON      = "R";
    localparam cmd_byte_t CMD_RED_OFF     = "r";
    localparam cmd_byte_t CMD_GREEN_ON    = "G";
    localparam cmd_byte_t CMD_GREEN_OFF   = "g";
    localparam cmd_byte_t CMD_BLUE_ON     = "B";
    localparam cmd_byte_t CMD_BLUE_OFF    = "b";
    localparam cmd_byte_t CMD_PLANE_FIRST = "1";
    localparam cmd_byte_t CMD_PLANE_LAST  = "6";
    localparam cmd_byte_t CMD_PLANES_OFF  = "0";
    localparam cmd_byte_t CMD_PLANES_ON   = "9";
    localparam cmd_byte_t CMD_LOAD_PLANES = "T";
    localparam cmd_byte_t CMD_PIXEL       = "P";
    localparam cmd_byte_t CMD_FILL        = "F";
    localparam cmd_byte_t CMD_BLANK       = "Z";

    typedef enum logic [2:0] {
        none,
        set_rgb,
        clr_rgb,
        toggle_plane,
        all_off,
        all_on,
        load_planes
    } settings_op_t;

    typedef enum logic [1:0] {
        pixel,
        fill,
        blank
    } write_mode_t;

    typedef enum logic [2:0] {
        idle,
        get_brightness,
        get_row,
        get_col,
        get_hi,
        get_lo,
        wait_writer
    } decoder_state_t;

endpackage
`default_nettype wire
